// ==== rtl/gx_video_pkg.sv ====
`default_nettype none

package gx_video_pkg;

    // ------------------------------
    // Mode port
    // ------------------------------
    localparam logic [7:0] MODE_PAGE  = 8'hBC;     // CPU address high byte
    localparam logic [4:0] SEL_CONFIG = 5'd0;      // Config mode register
    localparam logic [4:0] SEL_MRER   = 5'd1;      // MRER bits
    localparam logic [4:0] SEL_ASIC   = 5'd2;      // ASIC mode register

    // ASIC video modes that turn the ASIC on
    localparam logic [7:0] ASIC_MODE_PALETTE = 8'h02;  // Palette colour
    localparam logic [7:0] ASIC_MODE_SPRITE  = 8'h62;  // Sprite priority
    localparam logic [7:0] ASIC_MODE_BLEND   = 8'h82;  // Palette/GA average

    // ------------------------------
    // Pixel path
    // ------------------------------
    localparam logic [3:0] SPRITE_PAGE = 4'hF;     // crtc_ma[13:10] in sprite window

    localparam int CHAN_W     = 2;                 // Gate array colour per channel
    localparam int OUT_W      = 4;                 // Output colour per channel
    localparam int PAL_ADDR_W = 5;                 // {ra[2:0], ma[1:0]}

    // Mode-port data byte.
    // Low five bits select the register, and the
    // whole byte is also the value written.
    typedef union packed {
        logic [7:0] raw;                           // Value as written
        struct packed {
            logic [2:0] upper;                     // Mode bits above the select
            logic [4:0] sel;                       // Register select
        } f;
    } mode_byte_u;

endpackage

`default_nettype wire

// ==== rtl/gx_mode_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module gx_mode_regs (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        plus_mode,
    input  logic        cpu_wr,
    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_data,
    output logic [7:0]  config_mode,
    output logic [4:0]  mrer_mode,
    output logic [7:0]  asic_mode,
    output logic        asic_enabled
);
    import gx_video_pkg::*;

    mode_byte_u wr_byte;         // CPU byte, raw or split
    logic       port_wr;         // Write hits the mode port
    logic       asic_mode_ok;    // Written byte is a known ASIC mode

    assign wr_byte = cpu_data;

    // Page 0xBC, even addresses only
    assign port_wr = cpu_wr && (cpu_addr[15:8] == MODE_PAGE) && !cpu_addr[0];

    assign asic_mode_ok = (wr_byte.raw == ASIC_MODE_PALETTE) ||
                          (wr_byte.raw == ASIC_MODE_SPRITE) ||
                          (wr_byte.raw == ASIC_MODE_BLEND);

    // ------------------------------
    // Register update
    // ------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            config_mode  <= 8'h00;
            mrer_mode    <= 5'h00;
            asic_mode    <= 8'h00;
            asic_enabled <= 1'b0;
        end else if (port_wr) begin
            case (wr_byte.f.sel)
                SEL_CONFIG: config_mode <= wr_byte.raw;
                SEL_MRER:   mrer_mode   <= wr_byte.f.sel;  // Low five bits of the byte
                SEL_ASIC: begin
                    asic_mode    <= wr_byte.raw;
                    // Only in plus mode, sampled at the write
                    asic_enabled <= asic_mode_ok && plus_mode;
                end
                default: ;                                  // Other selects ignored
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gx_fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

// Stage 1 of the pixel pipeline
module gx_fetch_stage (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  logic                              cclk_en,
    input  logic                              crtc_de,
    input  logic                              asic_enabled,
    input  logic [13:0]                       crtc_ma,
    input  logic [4:0]                        crtc_ra,
    input  logic [gx_video_pkg::CHAN_W-1:0]   r_in,
    input  logic [gx_video_pkg::CHAN_W-1:0]   g_in,
    input  logic [gx_video_pkg::CHAN_W-1:0]   b_in,
    output logic                              s1_de,
    output logic [gx_video_pkg::CHAN_W-1:0]   s1_r,
    output logic [gx_video_pkg::CHAN_W-1:0]   s1_g,
    output logic [gx_video_pkg::CHAN_W-1:0]   s1_b,
    output logic                              s1_sprite_active,
    output logic [3:0]                        s1_sprite_id,
    output logic [gx_video_pkg::PAL_ADDR_W-1:0] asic_ram_addr,
    output logic                              asic_ram_rd
);
    import gx_video_pkg::*;

    logic                  sprite_hit;   // Top nibble of ma in sprite window
    logic [PAL_ADDR_W-1:0] pal_addr;     // Row and column into palette RAM

    assign sprite_hit = (crtc_ma[13:10] == SPRITE_PAGE);
    assign pal_addr   = {crtc_ra[2:0], crtc_ma[1:0]};

    // ------------------------------
    // Control bits
    // ------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            s1_de            <= 1'b0;
            s1_sprite_active <= 1'b0;
            asic_ram_rd      <= 1'b0;
        end else if (cclk_en) begin
            s1_de            <= crtc_de;
            s1_sprite_active <= crtc_de && sprite_hit;     // Never set in blanking
            // Held until the stage-2 sample
            asic_ram_rd      <= crtc_de && asic_enabled;
        end
    end

    // Pixel payload
    always_ff @(posedge clk_sys) begin
        if (cclk_en) begin
            s1_r         <= r_in;
            s1_g         <= g_in;
            s1_b         <= b_in;
            s1_sprite_id <= crtc_de ? crtc_ma[9:6] : 4'h0;
            if (crtc_de) begin
                asic_ram_addr <= pal_addr;                 // Address only moves in display
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gx_palette_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

// Stage 2, palette latch
module gx_palette_stage (
    input  logic                            clk_sys,
    input  logic                            reset,
    input  logic                            cclk_en,
    input  logic                            plus_mode,
    input  logic                            asic_enabled,
    input  logic [4:0]                      mrer_mode,
    input  logic [7:0]                      asic_ram_q,
    input  logic                            s1_de,
    input  logic                            s1_sprite_active,
    input  logic [gx_video_pkg::CHAN_W-1:0] s1_r,
    input  logic [gx_video_pkg::CHAN_W-1:0] s1_g,
    input  logic [gx_video_pkg::CHAN_W-1:0] s1_b,
    input  logic [3:0]                      s1_sprite_id,
    output logic                            s2_de,
    output logic                            s2_sprite_active,
    output logic [gx_video_pkg::CHAN_W-1:0] s2_r,
    output logic [gx_video_pkg::CHAN_W-1:0] s2_g,
    output logic [gx_video_pkg::CHAN_W-1:0] s2_b,
    output logic [3:0]                      s2_sprite_id,
    output logic [gx_video_pkg::OUT_W-1:0]  pal_r,
    output logic [gx_video_pkg::OUT_W-1:0]  pal_g,
    output logic [gx_video_pkg::OUT_W-1:0]  pal_b
);
    import gx_video_pkg::*;

    localparam int PAD_W = OUT_W - CHAN_W;   // Zero bits above a 2-bit channel

    logic use_ram;   // Take colour from palette RAM

    // MRER bit 0 gates the ASIC palette
    assign use_ram = plus_mode && asic_enabled && mrer_mode[0];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            s2_de            <= 1'b0;
            s2_sprite_active <= 1'b0;
        end else if (cclk_en) begin
            s2_de            <= s1_de;
            s2_sprite_active <= s1_sprite_active;
        end
    end

    // ------------------------------
    // Palette latch and payload
    // ------------------------------
    always_ff @(posedge clk_sys) begin
        if (cclk_en) begin
            s2_r         <= s1_r;
            s2_g         <= s1_g;
            s2_b         <= s1_b;
            s2_sprite_id <= s1_sprite_id;
            if (use_ram) begin
                pal_r <= {{PAD_W{1'b0}}, asic_ram_q[1:0]};   // R in bits 1:0
                pal_g <= {{PAD_W{1'b0}}, asic_ram_q[3:2]};
                pal_b <= {{PAD_W{1'b0}}, asic_ram_q[5:4]};
            end else begin
                pal_r <= {{PAD_W{1'b0}}, s1_r};              // Gate array colour
                pal_g <= {{PAD_W{1'b0}}, s1_g};
                pal_b <= {{PAD_W{1'b0}}, s1_b};
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gx_mix_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

// Stage 3, final colour
module gx_mix_stage (
    input  logic                            clk_sys,
    input  logic                            reset,
    input  logic                            cclk_en,
    input  logic                            plus_mode,
    input  logic                            asic_enabled,
    input  logic [7:0]                      config_mode,
    input  logic [7:0]                      asic_mode,
    input  logic                            s2_de,
    input  logic                            s2_sprite_active,
    input  logic [gx_video_pkg::CHAN_W-1:0] s2_r,
    input  logic [gx_video_pkg::CHAN_W-1:0] s2_g,
    input  logic [gx_video_pkg::CHAN_W-1:0] s2_b,
    input  logic [3:0]                      s2_sprite_id,
    input  logic [gx_video_pkg::OUT_W-1:0]  pal_r,
    input  logic [gx_video_pkg::OUT_W-1:0]  pal_g,
    input  logic [gx_video_pkg::OUT_W-1:0]  pal_b,
    output logic [gx_video_pkg::OUT_W-1:0]  r_out,
    output logic [gx_video_pkg::OUT_W-1:0]  g_out,
    output logic [gx_video_pkg::OUT_W-1:0]  b_out,
    output logic                            sprite_active_out,
    output logic [3:0]                      sprite_id_out
);
    import gx_video_pkg::*;

    logic use_ga;      // Plain gate array colour
    logic use_blend;   // Average of palette and GA

    // One channel of the mixer
    function automatic logic [OUT_W-1:0] mix_chan(input logic [OUT_W-1:0]  pal,
                                                  input logic [CHAN_W-1:0] ga,
                                                  input logic              ga_sel,
                                                  input logic              blend_sel);
        logic [OUT_W-1:0] ga_ext;
        logic [OUT_W:0]   sum;        // One extra bit for the carry
        ga_ext = {{(OUT_W - CHAN_W){1'b0}}, ga};
        sum    = {1'b0, pal} + {1'b0, ga_ext};
        if (ga_sel) begin
            return ga_ext;
        end else if (blend_sel) begin
            return sum[OUT_W:1];       // Halve, truncate
        end
        return pal;                    // Palette mode, or sprite pixel
    endfunction

    // Standard CPC path, or sprite mode outside a sprite
    assign use_ga = (config_mode == 8'h00) || !plus_mode || !asic_enabled ||
                    ((asic_mode == ASIC_MODE_SPRITE) && !s2_sprite_active);
    assign use_blend = (asic_mode == ASIC_MODE_BLEND);

    // ------------------------------
    // Output registers
    // ------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            r_out             <= '0;
            g_out             <= '0;
            b_out             <= '0;
            sprite_active_out <= 1'b0;
            sprite_id_out     <= 4'h0;
        end else if (cclk_en) begin
            sprite_active_out <= s2_sprite_active;   // Already 0 in blanking
            sprite_id_out     <= s2_sprite_id;
            if (s2_de) begin
                r_out <= mix_chan(pal_r, s2_r, use_ga, use_blend);
                g_out <= mix_chan(pal_g, s2_g, use_ga, use_blend);
                b_out <= mix_chan(pal_b, s2_b, use_ga, use_blend);
            end else begin
                r_out <= '0;                         // Black outside display
                g_out <= '0;
                b_out <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gx_video.sv ====
`timescale 1ns/10ps
`default_nettype none

module gx_video (
    input  logic                                clk_sys,
    input  logic                                reset,
    input  logic                                plus_mode,
    input  logic                                cclk_en,      // Character clock enable
    // CRTC and gate array pixel
    input  logic                                crtc_de,
    input  logic [13:0]                         crtc_ma,
    input  logic [4:0]                          crtc_ra,
    input  logic [gx_video_pkg::CHAN_W-1:0]     r_in,
    input  logic [gx_video_pkg::CHAN_W-1:0]     g_in,
    input  logic [gx_video_pkg::CHAN_W-1:0]     b_in,
    // CPU mode port
    input  logic                                cpu_wr,
    input  logic [15:0]                         cpu_addr,
    input  logic [7:0]                          cpu_data,
    // ASIC palette RAM
    output logic [gx_video_pkg::PAL_ADDR_W-1:0] asic_ram_addr,
    output logic                                asic_ram_rd,
    input  logic [7:0]                          asic_ram_q,
    // Video out
    output logic [gx_video_pkg::OUT_W-1:0]      r_out,
    output logic [gx_video_pkg::OUT_W-1:0]      g_out,
    output logic [gx_video_pkg::OUT_W-1:0]      b_out,
    output logic                                sprite_active_out,
    output logic [3:0]                          sprite_id_out
);
    import gx_video_pkg::*;

    // ------------------------------
    // Mode registers
    // ------------------------------
    logic [7:0] config_mode;
    logic [4:0] mrer_mode;
    logic [7:0] asic_mode;
    logic       asic_enabled;

    // Stage 1 to 2
    logic              s1_de, s1_sprite_active;
    logic [CHAN_W-1:0] s1_r, s1_g, s1_b;
    logic [3:0]        s1_sprite_id;

    // Stage 2 to 3
    logic              s2_de, s2_sprite_active;
    logic [CHAN_W-1:0] s2_r, s2_g, s2_b;
    logic [3:0]        s2_sprite_id;
    logic [OUT_W-1:0]  pal_r, pal_g, pal_b;

    gx_mode_regs u_mode_regs (
        .clk_sys(clk_sys), .reset(reset), .plus_mode(plus_mode),
        .cpu_wr(cpu_wr), .cpu_addr(cpu_addr), .cpu_data(cpu_data),
        .config_mode(config_mode), .mrer_mode(mrer_mode),
        .asic_mode(asic_mode), .asic_enabled(asic_enabled)
    );

    gx_fetch_stage u_fetch (
        .clk_sys(clk_sys), .reset(reset), .cclk_en(cclk_en),
        .crtc_de(crtc_de), .asic_enabled(asic_enabled),
        .crtc_ma(crtc_ma), .crtc_ra(crtc_ra),
        .r_in(r_in), .g_in(g_in), .b_in(b_in),
        .s1_de(s1_de), .s1_r(s1_r), .s1_g(s1_g), .s1_b(s1_b),
        .s1_sprite_active(s1_sprite_active), .s1_sprite_id(s1_sprite_id),
        .asic_ram_addr(asic_ram_addr), .asic_ram_rd(asic_ram_rd)
    );

    // RAM byte is back before the next enable
    gx_palette_stage u_palette (
        .clk_sys(clk_sys), .reset(reset), .cclk_en(cclk_en),
        .plus_mode(plus_mode), .asic_enabled(asic_enabled),
        .mrer_mode(mrer_mode), .asic_ram_q(asic_ram_q),
        .s1_de(s1_de), .s1_sprite_active(s1_sprite_active),
        .s1_r(s1_r), .s1_g(s1_g), .s1_b(s1_b), .s1_sprite_id(s1_sprite_id),
        .s2_de(s2_de), .s2_sprite_active(s2_sprite_active),
        .s2_r(s2_r), .s2_g(s2_g), .s2_b(s2_b), .s2_sprite_id(s2_sprite_id),
        .pal_r(pal_r), .pal_g(pal_g), .pal_b(pal_b)
    );

    gx_mix_stage u_mix (
        .clk_sys(clk_sys), .reset(reset), .cclk_en(cclk_en),
        .plus_mode(plus_mode), .asic_enabled(asic_enabled),
        .config_mode(config_mode), .asic_mode(asic_mode),
        .s2_de(s2_de), .s2_sprite_active(s2_sprite_active),
        .s2_r(s2_r), .s2_g(s2_g), .s2_b(s2_b), .s2_sprite_id(s2_sprite_id),
        .pal_r(pal_r), .pal_g(pal_g), .pal_b(pal_b),
        .r_out(r_out), .g_out(g_out), .b_out(b_out),
        .sprite_active_out(sprite_active_out), .sprite_id_out(sprite_id_out)
    );

endmodule

`default_nettype wire

// ==== tb/tb_palette_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

// ASIC palette RAM model, combinational read
module tb_palette_ram (
    input  logic                                clk_sys,
    input  logic                                load_wr,     // Fill port from stim records
    input  logic [gx_video_pkg::PAL_ADDR_W-1:0] load_addr,
    input  logic [7:0]                          load_data,
    input  logic                                rd,
    input  logic [gx_video_pkg::PAL_ADDR_W-1:0] addr,
    output logic [7:0]                          q
);
    import gx_video_pkg::*;

    logic [7:0] mem [0:(1 << PAL_ADDR_W) - 1];

    // Background pattern, different at every address
    initial begin
        for (int i = 0; i < (1 << PAL_ADDR_W); i++) begin
            mem[i] = 8'hC3 ^ 8'(i * 37);
        end
    end

    always @(posedge clk_sys) begin
        if (load_wr) begin
            mem[load_addr] <= load_data;
        end
    end

    assign q = rd ? mem[addr] : 8'h00;     // Bus idles low without a read

endmodule

`default_nettype wire

// ==== tb/tb_gx_video.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_gx_video;
    import gx_video_pkg::*;

    localparam int DRAIN_LIMIT = 8;     // Enables allowed to empty the pipeline

    // ------------------------------
    // DUT and RAM signals
    // ------------------------------
    logic                  clk_sys;
    logic                  reset;
    logic                  plus_mode;
    logic                  cclk_en;
    logic                  crtc_de;
    logic [13:0]           crtc_ma;
    logic [4:0]            crtc_ra;
    logic [CHAN_W-1:0]     r_in, g_in, b_in;
    logic                  cpu_wr;
    logic [15:0]           cpu_addr;
    logic [7:0]            cpu_data;
    logic [PAL_ADDR_W-1:0] asic_ram_addr;
    logic                  asic_ram_rd;
    logic [7:0]            asic_ram_q;
    logic [OUT_W-1:0]      r_out, g_out, b_out;
    logic                  sprite_active_out;
    logic [3:0]            sprite_id_out;
    logic                  load_wr;
    logic [PAL_ADDR_W-1:0] load_addr;
    logic [7:0]            load_data;

    logic [16:0] exp_q[$];      // {r, g, b, sprite, id}
    logic [2:0]  in_flight;     // Real pixel per enable with bit 2 at the outputs
    integer      seed;
    int          compares;
    int          errors;
    logic        timed_out;

    gx_video DUT (
        .clk_sys(clk_sys), .reset(reset), .plus_mode(plus_mode), .cclk_en(cclk_en),
        .crtc_de(crtc_de), .crtc_ma(crtc_ma), .crtc_ra(crtc_ra),
        .r_in(r_in), .g_in(g_in), .b_in(b_in),
        .cpu_wr(cpu_wr), .cpu_addr(cpu_addr), .cpu_data(cpu_data),
        .asic_ram_addr(asic_ram_addr), .asic_ram_rd(asic_ram_rd), .asic_ram_q(asic_ram_q),
        .r_out(r_out), .g_out(g_out), .b_out(b_out),
        .sprite_active_out(sprite_active_out), .sprite_id_out(sprite_id_out)
    );

    tb_palette_ram u_palette_ram (
        .clk_sys(clk_sys), .load_wr(load_wr), .load_addr(load_addr), .load_data(load_data),
        .rd(asic_ram_rd), .addr(asic_ram_addr), .q(asic_ram_q)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;     // 50 MHz
    end

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        compares++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // ------------------------------
    // One clk_sys cycle with scoreboard on enables
    // ------------------------------
    task automatic run_cycle(input logic en, input logic valid);
        logic [16:0] exp;
        cclk_en = en;
        @(posedge clk_sys);
        #2;
        if (en) begin
            in_flight = {in_flight[1:0], valid};
            if (in_flight[2]) begin
                exp = exp_q.pop_front();
                check_value("r_out", r_out, exp[16:13]);
                check_value("g_out", g_out, exp[12:9]);
                check_value("b_out", b_out, exp[8:5]);
                check_value("sprite_active_out", sprite_active_out, exp[4]);
                check_value("sprite_id_out", sprite_id_out, exp[3:0]);
            end
        end
    endtask

    // Pixel after a random gap of idle cycles
    task automatic push_pixel(input logic pix_de, input logic [13:0] pix_ma,
                              input logic [4:0] pix_ra, input logic [1:0] pix_r,
                              input logic [1:0] pix_g, input logic [1:0] pix_b,
                              input logic [16:0] exp);
        int gap;
        gap     = $unsigned($random(seed)) % 3;
        crtc_de = pix_de;
        crtc_ma = pix_ma;
        crtc_ra = pix_ra;
        r_in    = pix_r;
        g_in    = pix_g;
        b_in    = pix_b;
        exp_q.push_back(exp);
        repeat (gap) run_cycle(1'b0, 1'b0);
        run_cycle(1'b1, 1'b1);
    endtask

    // Blank pixels until every queued result is checked
    task automatic drain_pipeline();
        int guard;
        guard   = 0;
        crtc_de = 1'b0;
        while (exp_q.size() != 0 && guard < DRAIN_LIMIT) begin
            run_cycle(1'b1, 1'b0);
            guard++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: %0d pixels never reached the outputs", exp_q.size());
        end
    endtask

    task automatic write_mode(input logic plus, input logic [15:0] addr,
                              input logic [2:0] upper, input logic [4:0] sel);
        mode_byte_u mb;
        drain_pipeline();
        mb.f.upper = upper;
        mb.f.sel   = sel;
        plus_mode  = plus;      // Level held until the next W record
        cpu_addr   = addr;
        cpu_data   = mb.raw;
        cpu_wr     = 1'b1;
        run_cycle(1'b0, 1'b0);
        cpu_wr     = 1'b0;
    endtask

    task automatic load_palette(input logic [4:0] addr, input logic [7:0] data);
        drain_pipeline();
        load_wr   = 1'b1;
        load_addr = addr;
        load_data = data;
        run_cycle(1'b0, 1'b0);
        load_wr   = 1'b0;
    endtask

    // ------------------------------
    // Stimulus replay
    // ------------------------------
    initial begin
        int         fd;
        int         n;
        string      line;
        logic [7:0] kind;
        int         de, ma, ra, r, g, b, er, eg, eb, es, ei;
        int         plus, addr, data, upper, sel;
        seed      = 36519;
        compares  = 0;
        errors    = 0;
        timed_out = 1'b0;
        in_flight = 3'b000;
        reset     = 1'b1;
        plus_mode = 1'b0;
        cclk_en   = 1'b0;
        crtc_de   = 1'b0;
        crtc_ma   = '0;
        crtc_ra   = '0;
        r_in      = '0;
        g_in      = '0;
        b_in      = '0;
        cpu_wr    = 1'b0;
        cpu_addr  = '0;
        cpu_data  = '0;
        load_wr   = 1'b0;
        load_addr = '0;
        load_data = '0;
        repeat (3) @(posedge clk_sys);
        #2;
        reset = 1'b0;
        check_value("r_out", r_out, 8'h00);             // Reset values
        check_value("g_out", g_out, 8'h00);
        check_value("b_out", b_out, 8'h00);
        check_value("sprite_active_out", sprite_active_out, 8'h00);
        check_value("asic_ram_rd", asic_ram_rd, 8'h00);

        fd = $fopen("tb/gx_video_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file tb/gx_video_stim.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    kind = line.getc(0);
                    case (kind)
                        "P": begin
                            n = $sscanf(line, "%c %h %h", kind, addr, data);
                            if (n != 3) begin
                                errors++;
                                $display("Malformed palette record: %s", line);
                            end
                            load_palette(addr[4:0], data[7:0]);
                        end
                        "W": begin
                            n = $sscanf(line, "%c %h %h %h %h", kind, plus, addr, upper, sel);
                            if (n != 5) begin
                                errors++;
                                $display("Malformed mode write record: %s", line);
                            end
                            write_mode(plus[0], addr[15:0], upper[2:0], sel[4:0]);
                        end
                        "X": begin
                            n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h", kind,
                                        de, ma, ra, r, g, b, er, eg, eb, es, ei);
                            if (n != 12) begin
                                errors++;
                                $display("Malformed pixel record: %s", line);
                            end
                            push_pixel(de[0], ma[13:0], ra[4:0], r[1:0], g[1:0], b[1:0],
                                       {er[3:0], eg[3:0], eb[3:0], es[0], ei[3:0]});
                        end
                        default: begin
                            if (kind != "#" && kind != 8'h0a && kind != 8'h0d) begin
                                errors++;
                                $display("Unknown record in stimulus file: %s", line);
                            end
                        end
                    endcase
                end
            end
            $fclose(fd);
            if (!timed_out) begin
                drain_pipeline();
            end
        end

        $display("Compares: %0d, errors: %0d", compares, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/gx_video_stim.txt ====
# P ram_addr byte | W plus_mode cpu_addr upper sel (byte = {upper, sel})
# X de ma ra r g b | expected r g b sprite id (all hex)
P 05 1b
P 0a 24
P 13 36
P 1f 3f
# Standard colour after reset, black in blanking
X 1 0005 01 1 2 3 1 2 3 0 0
X 0 0005 01 3 3 3 0 0 0 0 0
X 1 3c80 01 2 0 1 2 0 1 1 2
X 0 3c80 01 1 1 1 0 0 0 0 0
# Config 0x20, ASIC 0x02, MRER bit 0 still clear
W 1 bc00 1 00
W 1 bc00 0 02
X 1 0005 01 1 1 0 1 1 0 0 0
W 1 bc00 0 01
X 1 0005 01 0 0 0 3 2 1 0 0
X 1 000a 02 3 3 3 0 1 2 0 0
X 1 0003 0c 0 0 0 2 1 3 0 0
X 1 3c43 07 0 0 0 3 3 3 1 1
X 0 3c43 07 2 2 2 0 0 0 0 0
# Sprite priority 0x62
W 1 bc00 3 02
X 1 3dc5 01 0 0 0 3 2 1 1 7
X 1 0005 01 2 3 0 2 3 0 0 0
X 1 1f0a 02 1 0 2 1 0 2 0 c
# Blend 0x82
W 1 bc00 4 02
X 1 0005 01 1 2 3 2 2 2 0 0
X 1 000a 02 3 0 1 1 0 1 0 0
X 1 0003 0c 2 2 2 2 1 2 0 0
X 1 3cdf 07 0 1 2 1 2 2 1 3
# ASIC write with plus_mode low, then ignored writes
W 0 bc00 0 02
X 1 0005 01 3 1 2 3 1 2 0 0
W 1 bd00 0 02
X 1 0005 01 0 2 1 0 2 1 0 0
W 1 bc00 0 02
X 1 000a 02 3 3 3 0 1 2 0 0
W 1 bd00 3 02
X 1 0005 01 0 0 0 3 2 1 0 0
W 1 bc01 0 00
X 1 0003 0c 1 1 1 2 1 3 0 0

// ==== compile.f ====
rtl/gx_video_pkg.sv
rtl/gx_mode_regs.sv
rtl/gx_fetch_stage.sv
rtl/gx_palette_stage.sv
rtl/gx_mix_stage.sv
rtl/gx_video.sv
tb/tb_palette_ram.sv
tb/tb_gx_video.sv
